/* files.f */
hdl/led_matrix_pkg.sv
hdl/host_bus_pkg.sv
hdl/framebuffer_ram.sv
hdl/fb_arbiter.sv
hdl/host_port.sv
hdl/column_fetch.sv
hdl/column_mux.sv
hdl/led_matrix_top.sv
verification/led_matrix_tb.sv

/* hdl/column_fetch.sv */
/*
 * Reads the next column bitmap through the arbiter before each lit period.
 * Latency is 2 cycles plus any cycles lost to host writes.
 */
`timescale 1ns/1ns

module column_fetch (
   input  logic                      clk_33,
   input  logic                      nrst,
   input  logic                      fetch_start,
   input  led_matrix_pkg::col_index_t next_col,
   input  logic                      display_enable,
   output logic                      fetch_req_valid,
   output host_bus_pkg::fb_req_t      fetch_req,
   input  logic                      fetch_grant,
   input  logic                      fetch_rsp_valid,
   input  host_bus_pkg::fb_rsp_t      fetch_rsp,
   output logic                      column_ready,
   output led_matrix_pkg::row_bits_t  row_out
);

   import led_matrix_pkg::*;
   import host_bus_pkg::*;

   typedef enum logic [1:0] {
      st_idle,                                        // nothing to fetch.
      st_req,                                         // host holds the memory.
      st_data                                         // read granted, data next.
   } fetch_state_t;

   fetch_state_t state;
   row_bits_t    row_q;                               // bitmap of the coming column.

   // request goes out in the start cycle already.
   assign fetch_req_valid = (state == st_idle && fetch_start) || (state == st_req);

   always_comb begin
      fetch_req.wr   = 1'b0;                          // read only.
      fetch_req.col  = next_col;                      // stable while mux waits.
      fetch_req.data = '0;
   end

   always_ff @(posedge clk_33 or negedge nrst) begin
      if (!nrst) begin
         state        <= st_idle;
         column_ready <= 1'b0;
      end else begin
         column_ready <= 1'b0;                        // single-cycle pulse.
         case (state)
            st_idle: begin
               if (fetch_start) begin
                  state <= fetch_grant ? st_data : st_req;
               end
            end
            st_req: begin
               if (fetch_grant) begin
                  state <= st_data;
               end
            end
            st_data: begin
               if (fetch_rsp_valid) begin
                  state        <= st_idle;
                  column_ready <= 1'b1;               // row_q valid with this pulse.
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // bitmap latch, loaded together with column_ready.
   always_ff @(posedge clk_33) begin
      if (state == st_data && fetch_rsp_valid) begin
         row_q <= fetch_rsp.data;
      end
   end

   assign row_out = display_enable ? row_q : '0;      // blank rows when disabled.

endmodule

/* hdl/column_mux.sv */
/*
 * Column scan FSM. Each column stays lit for exactly drive_clock_cycles.
 * The dark gap between columns stretches with the fetch latency.
 */
`timescale 1ns/1ns

module column_mux (
   input  logic                              clk_33,
   input  logic                              nrst,
   input  logic                              column_ready,
   output logic                              fetch_start,
   output led_matrix_pkg::col_index_t        next_col,
   output logic [led_matrix_pkg::num_cols-1:0] col_out
);

   import led_matrix_pkg::*;

   typedef enum logic [1:0] {
      st_boot,                                        // first cycle out of reset.
      st_wait,                                        // dark, waiting for bitmap.
      st_lit                                          // one column on.
   } mux_state_t;

   mux_state_t                  state;
   col_index_t                  col_idx;              // column to light.
   logic [drive_clock_bits-1:0] drive_cnt;            // cycles spent lit.

   always_ff @(posedge clk_33 or negedge nrst) begin
      if (!nrst) begin
         state       <= st_boot;
         col_idx     <= '0;
         drive_cnt   <= '0;
         fetch_start <= 1'b0;
      end else begin
         fetch_start <= 1'b0;                         // pulse by default.
         case (state)
            st_boot: begin
               state       <= st_wait;
               fetch_start <= 1'b1;                   // first fetch, column 0.
            end
            st_wait: begin
               drive_cnt <= '0;
               if (column_ready) begin
                  state <= st_lit;                    // lit from the next cycle.
               end
            end
            st_lit: begin
               if (drive_cnt == drive_clock_bits'(drive_clock_cycles - 1)) begin
                  state       <= st_wait;
                  fetch_start <= 1'b1;                // fetch the following column.
                  drive_cnt   <= '0;
                  if (col_idx == col_index_t'(num_cols - 1)) begin
                     col_idx <= '0;                   // wrap to first column.
                  end else begin
                     col_idx <= col_idx + 1'b1;
                  end
               end else begin
                  drive_cnt <= drive_cnt + 1'b1;
               end
            end
            default: state <= st_boot;
         endcase
      end
   end

   // index already points at the column being fetched.
   assign next_col = col_idx;

   // one-hot column drive, dark outside the lit state.
   always_comb begin
      col_out = '0;
      if (state == st_lit) begin
         col_out[col_idx] = 1'b1;
      end
   end

endmodule

/* hdl/fb_arbiter.sv */
/*
 * Fixed-priority access to the framebuffer, host first.
 * The fetcher waits as long as the host keeps writing.
 */
`timescale 1ns/1ns

module fb_arbiter (
   input  logic                 clk_33,
   input  logic                 nrst,
   input  logic                 host_req_valid,
   input  host_bus_pkg::fb_req_t host_req,
   input  logic                 fetch_req_valid,
   input  host_bus_pkg::fb_req_t fetch_req,
   output logic                 fetch_grant,
   output logic                 fetch_rsp_valid,
   output host_bus_pkg::fb_rsp_t fetch_rsp
);

   import host_bus_pkg::*;

   logic    ram_req_valid;                            // any access this cycle.
   fb_req_t ram_req;                                  // winning request.
   fb_rsp_t ram_rsp;
   logic    fetch_rd_q;                               // fetch read in flight.

   // host wins whenever it asks.
   assign fetch_grant = fetch_req_valid && !host_req_valid;

   always_comb begin
      ram_req_valid = host_req_valid || fetch_req_valid;
      if (host_req_valid) begin
         ram_req = host_req;
      end else begin
         ram_req = fetch_req;                         // also idle default.
      end
   end

   // data follows a granted fetch by one cycle.
   always_ff @(posedge clk_33 or negedge nrst) begin
      if (!nrst) begin
         fetch_rd_q <= 1'b0;
      end else begin
         fetch_rd_q <= fetch_grant;
      end
   end

   assign fetch_rsp_valid = fetch_rd_q;
   assign fetch_rsp       = ram_rsp;                  // rsp only moves on reads.

   framebuffer_ram ram_i (
      .clk_33    (clk_33),
      .nrst      (nrst),
      .req_valid (ram_req_valid),
      .req       (ram_req),
      .rsp       (ram_rsp)
   );

endmodule

/* hdl/framebuffer_ram.sv */
/*
 * Column bitmap store, one entry per column. Cleared by reset.
 * Reads return data one cycle later, rsp holds until the next read.
 */
`timescale 1ns/1ns

module framebuffer_ram (
   input  logic                 clk_33,
   input  logic                 nrst,
   input  logic                 req_valid,
   input  host_bus_pkg::fb_req_t req,
   output host_bus_pkg::fb_rsp_t rsp
);

   import led_matrix_pkg::*;

   row_bits_t mem [num_cols];                         // one bitmap per column.

   always_ff @(posedge clk_33 or negedge nrst) begin
      if (!nrst) begin
         for (int i = 0; i < num_cols; i++) begin
            mem[i] <= '0;                             // blank display after reset.
         end
         rsp <= '0;
      end else if (req_valid) begin
         if (req.wr) begin
            mem[req.col] <= req.data;                 // write lands at this edge.
         end else begin
            rsp.data <= mem[req.col];                 // registered read.
         end
      end
   end

endmodule

/* hdl/host_bus_pkg.sv */
/*
 * Host command word and framebuffer request/response types.
 * Payload decode depends on op. Spare control bits are ignored.
 */
package host_bus_pkg;

   import led_matrix_pkg::*;

   // command kind carried in the top bit of the word.
   typedef enum logic {
      op_fb_write = 1'b0,                 // write one column bitmap.
      op_ctrl     = 1'b1                  // update control register.
   } host_op_t;

   // payload of a column write, 11 bits.
   typedef struct packed {
      col_index_t col;                    // target column.
      row_bits_t  rows;                   // new bitmap.
   } fb_write_t;

   // payload of a control command, 11 bits.
   typedef struct packed {
      logic       enable;                 // display enable.
      logic [9:0] spare;                  // reserved, write as zero.
   } ctrl_t;

   // same 11 bits, decoded by op.
   typedef union packed {
      fb_write_t fb_write;
      ctrl_t     ctrl;
   } host_payload_u;

   // full 12-bit host command.
   typedef struct packed {
      host_op_t      op;
      host_payload_u payload;
   } host_cmd_t;

   // framebuffer access, write when wr is set, read otherwise.
   typedef struct packed {
      logic       wr;
      col_index_t col;                    // entry address.
      row_bits_t  data;                   // write data, don't care on reads.
   } fb_req_t;

   // read data, one cycle after the read.
   typedef struct packed {
      row_bits_t data;
   } fb_rsp_t;

endpackage

/* hdl/host_port.sv */
/*
 * Host command decoder. Strobes are never stalled.
 * Writes pass through in the strobe cycle, enable changes one cycle later.
 */
`timescale 1ns/1ns

module host_port (
   input  logic                   clk_33,
   input  logic                   nrst,
   input  logic                   host_valid,
   input  host_bus_pkg::host_cmd_t host_cmd,
   output logic                   host_req_valid,
   output host_bus_pkg::fb_req_t   host_req,
   output logic                   display_enable
);

   import host_bus_pkg::*;

   logic is_write;                                    // column write strobe.
   logic is_ctrl;                                     // control strobe.

   assign is_write = host_valid && (host_cmd.op == op_fb_write);
   assign is_ctrl  = host_valid && (host_cmd.op == op_ctrl);

   // write request straight from the payload.
   always_comb begin
      host_req_valid = is_write;
      host_req.wr    = 1'b1;
      host_req.col   = host_cmd.payload.fb_write.col;
      host_req.data  = host_cmd.payload.fb_write.rows;
   end

   // control register, spare bits dropped.
   always_ff @(posedge clk_33 or negedge nrst) begin
      if (!nrst) begin
         display_enable <= 1'b0;                      // dark until enabled.
      end else if (is_ctrl) begin
         display_enable <= host_cmd.payload.ctrl.enable;
      end
   end

endmodule

/* hdl/led_matrix_pkg.sv */
/*
 * Geometry and scan timing of the 8x8 LED matrix.
 * Drive time assumes a 33 MHz clk_33. Never raise it above 10 us at full current.
 */
package led_matrix_pkg;

   // matrix geometry, fixed by the board.
   localparam int num_cols = 8;                        // columns scanned one at a time.
   localparam int num_rows = 8;                        // row lines driven per column.
   localparam int col_index_bits = $clog2(num_cols);   // 3 bits for 8 columns.

   // one lit column lasts 10 us, about 30 ns per clock.
   localparam int drive_clock_cycles = 330;
   localparam int drive_clock_bits = $clog2(drive_clock_cycles);  // 9 bits, holds 0..329.

   // column number, 0 is the leftmost column.
   typedef logic [col_index_bits-1:0] col_index_t;

   // row bitmap of one column, bit n lights row n.
   typedef logic [num_rows-1:0] row_bits_t;

endpackage

/* hdl/led_matrix_top.sv */
/*
 * 8x8 LED matrix driver top. Host writes show up at the next fetch
 * of that column, at most one frame later.
 */
`timescale 1ns/1ns

module led_matrix_top (
   input  logic                              clk_33,
   input  logic                              nrst,
   input  logic                              host_valid,
   input  host_bus_pkg::host_cmd_t            host_cmd,
   output logic [led_matrix_pkg::num_cols-1:0] col_out,
   output led_matrix_pkg::row_bits_t          row_out
);

   import led_matrix_pkg::*;
   import host_bus_pkg::*;

   logic       host_req_valid;                        // host write to memory.
   fb_req_t    host_req;
   logic       display_enable;
   logic       fetch_req_valid;                       // fetcher read request.
   fb_req_t    fetch_req;
   logic       fetch_grant;
   logic       fetch_rsp_valid;
   fb_rsp_t    fetch_rsp;
   logic       fetch_start;                           // mux asks for next bitmap.
   col_index_t next_col;
   logic       column_ready;                          // bitmap latched.

   host_port host_port_i (
      .clk_33         (clk_33),
      .nrst           (nrst),
      .host_valid     (host_valid),
      .host_cmd       (host_cmd),
      .host_req_valid (host_req_valid),
      .host_req       (host_req),
      .display_enable (display_enable)
   );

   fb_arbiter fb_arbiter_i (
      .clk_33          (clk_33),
      .nrst            (nrst),
      .host_req_valid  (host_req_valid),
      .host_req        (host_req),
      .fetch_req_valid (fetch_req_valid),
      .fetch_req       (fetch_req),
      .fetch_grant     (fetch_grant),
      .fetch_rsp_valid (fetch_rsp_valid),
      .fetch_rsp       (fetch_rsp)
   );

   column_fetch column_fetch_i (
      .clk_33          (clk_33),
      .nrst            (nrst),
      .fetch_start     (fetch_start),
      .next_col        (next_col),
      .display_enable  (display_enable),
      .fetch_req_valid (fetch_req_valid),
      .fetch_req       (fetch_req),
      .fetch_grant     (fetch_grant),
      .fetch_rsp_valid (fetch_rsp_valid),
      .fetch_rsp       (fetch_rsp),
      .column_ready    (column_ready),
      .row_out         (row_out)
   );

   column_mux column_mux_i (
      .clk_33       (clk_33),
      .nrst         (nrst),
      .column_ready (column_ready),
      .fetch_start  (fetch_start),
      .next_col     (next_col),
      .col_out      (col_out)
   );

endmodule

/* verification/led_matrix_tb.sv */
/*
 * Table-driven testbench for the LED matrix driver. Writes land in the DUT at once but
 * show only from the second lit column after a command, so checks start there.
 */
`timescale 1ns/1ns

module led_matrix_tb;

   import led_matrix_pkg::*;
   import host_bus_pkg::*;

   typedef struct packed {
      host_cmd_t                    cmd;              // command, or template for a burst.
      logic                         rand_fill;        // random rows, column steps per rep.
      logic [4:0]                   reps;             // back-to-back strobes.
      logic                         wait_frames;      // check two frames after this step.
      logic                         use_model;        // expected bitmaps from the model.
      row_bits_t [num_cols-1:0]     exp;              // expected bitmap per column.
   } step_t;

   localparam int num_steps   = 16;
   localparam int frame_cycles = num_cols * (drive_clock_cycles + 8);  // lit time plus gap.
   localparam int check_starts = 1 + 2 * num_cols;   // one stale column, then two frames.

   logic                  clk_33 = 1'b0;
   logic                  nrst;
   logic                  host_valid;
   host_cmd_t             host_cmd;
   logic [num_cols-1:0]   col_out;
   row_bits_t             row_out;

   step_t     steps [num_steps];
   row_bits_t model_fb [num_cols];                    // reference framebuffer.
   logic      model_en = 1'b0;                        // reference enable.
   row_bits_t exp_view [num_cols];                    // what row_out must show.
   int        seed;
   int        cycle_count = 0;
   int        cycle_limit = 100000;                   // replaced once the table is built.
   int        error_count = 0;
   int        check_count = 0;
   int        starts = 0;                             // lit columns since last command.
   int        lit_total = 0;
   int        lit_len = 0;
   int        lit_col;
   int        last_col = num_cols - 1;                // so the first column must be 0.
   bit        check_en = 1'b0;
   logic [num_cols-1:0] prev_col_out = '0;

   always #10 clk_33 = ~clk_33;                       // 20 ns period.

   led_matrix_top dut_i (
      .clk_33     (clk_33),
      .nrst       (nrst),
      .host_valid (host_valid),
      .host_cmd   (host_cmd),
      .col_out    (col_out),
      .row_out    (row_out)
   );

   function automatic host_cmd_t write_cmd(int col, row_bits_t rows);
      host_cmd_t c;
      c.op                    = op_fb_write;
      c.payload.fb_write.col  = col_index_t'(col);
      c.payload.fb_write.rows = rows;
      return c;
   endfunction

   function automatic host_cmd_t ctrl_cmd(logic en, logic [9:0] spare);
      host_cmd_t c;
      c.op                   = op_ctrl;
      c.payload.ctrl.enable  = en;
      c.payload.ctrl.spare   = spare;
      return c;
   endfunction

   function automatic step_t make_step(host_cmd_t cmd, bit rnd, int reps, bit wt, bit mdl,
                                       logic [63:0] exp);
      step_t s;
      s.cmd         = cmd;
      s.rand_fill   = rnd;
      s.reps        = 5'(reps);
      s.wait_frames = wt;
      s.use_model   = mdl;
      s.exp         = exp;
      return s;
   endfunction

   function automatic int onehot_index(logic [num_cols-1:0] v);
      int idx;
      idx = -1;
      for (int i = 0; i < num_cols; i++) begin
         if (v[i]) idx = i;
      end
      return idx;
   endfunction

   task automatic flag_mismatch(string msg);
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
      error_count++;
   endtask

   task automatic apply_to_model(host_cmd_t c);
      if (c.op == op_fb_write) begin
         model_fb[c.payload.fb_write.col] = c.payload.fb_write.rows;
      end else begin
         model_en = c.payload.ctrl.enable;            // spare bits have no effect.
      end
   endtask

   // run limit, three frames per checked step plus one cycle per strobe.
   always @(posedge clk_33) begin
      cycle_count++;
      if (cycle_count >= cycle_limit) begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         $display("Done: errors found");
         $finish;
      end
   end

   // scan monitor, outputs sampled mid-cycle.
   always @(negedge clk_33) begin
      check_count++;
      if (!nrst) begin
         assert (col_out == '0 && row_out == '0) else flag_mismatch("outputs not dark in reset");
      end else begin
         assert ((col_out & (col_out - 1'b1)) == '0)
            else flag_mismatch($sformatf("col_out %b not one-hot", col_out));
         if (lit_total == 0 && !model_en) begin
            assert (row_out == '0) else flag_mismatch("row_out not zero before first column");
         end
         if (col_out != '0 && prev_col_out == '0) begin  // a column turns on.
            lit_col = onehot_index(col_out);
            starts++;
            lit_total++;
            lit_len = 1;
            assert (lit_col == (last_col + 1) % num_cols)
               else flag_mismatch($sformatf("column %0d lit after %0d", lit_col, last_col));
            last_col = lit_col;
            if (check_en && starts >= 2) begin
               check_count++;
               assert (row_out == exp_view[lit_col])
                  else flag_mismatch($sformatf("column %0d rows %h, expected %h",
                                               lit_col, row_out, exp_view[lit_col]));
            end
         end else if (col_out != '0) begin
            lit_len++;
         end else if (prev_col_out != '0) begin     // column just went dark.
            check_count++;
            assert (lit_len == drive_clock_cycles)
               else flag_mismatch($sformatf("column %0d lit for %0d cycles, expected %0d",
                                            last_col, lit_len, drive_clock_cycles));
         end
      end
      prev_col_out = col_out;
   end

   initial begin
      int        num_waits;
      host_cmd_t cmd;
      seed       = 32'ha2ecf35f;
      nrst       = 1'b0;
      host_valid = 1'b0;
      host_cmd   = '0;
      for (int c = 0; c < num_cols; c++) begin
         model_fb[c] = '0;                            // DUT memory clears on reset.
         steps[c]    = make_step(write_cmd(c, row_bits_t'(1 << c)), 0, 1, 0, 0, '0);
      end
      steps[8]  = make_step(ctrl_cmd(1'b1, '0), 0, 1, 1, 0, 64'h8040201008040201);
      steps[9]  = make_step(ctrl_cmd(1'b0, '0), 0, 1, 1, 0, 64'h0);
      steps[10] = make_step(ctrl_cmd(1'b1, '0), 0, 1, 1, 0, 64'h8040201008040201);
      steps[11] = make_step(write_cmd(2, 8'ha5), 0, 1, 0, 0, '0);
      steps[12] = make_step(write_cmd(5, 8'h3c), 0, 1, 1, 0, 64'h80403c1008a50201);
      steps[13] = make_step(write_cmd(0, '0), 1, 16, 0, 1, '0);   // random burst.
      steps[14] = make_step(write_cmd(3, '0), 1, 5, 1, 1, '0);
      steps[15] = make_step(ctrl_cmd(1'b0, 10'h3ff), 0, 1, 1, 0, 64'h0);
      num_waits = 0;
      for (int s = 0; s < num_steps; s++) begin
         if (steps[s].wait_frames) num_waits++;
      end
      cycle_limit = num_waits * 3 * frame_cycles + num_steps * 32 + 1000;
      repeat (2) @(posedge clk_33);
      nrst <= 1'b1;
      @(posedge clk_33);
      for (int s = 0; s < num_steps; s++) begin
         for (int r = 0; r < steps[s].reps; r++) begin
            cmd = steps[s].cmd;
            if (steps[s].rand_fill) begin
               cmd.payload.fb_write.col  = col_index_t'(steps[s].cmd.payload.fb_write.col + r);
               cmd.payload.fb_write.rows = row_bits_t'($random(seed));
            end
            apply_to_model(cmd);
            host_valid <= 1'b1;
            host_cmd   <= cmd;
            @(posedge clk_33);                        // DUT takes the strobe here.
         end
         if (steps[s].wait_frames) begin
            host_valid <= 1'b0;
            for (int c = 0; c < num_cols; c++) begin
               if (steps[s].use_model) begin
                  exp_view[c] = model_en ? model_fb[c] : '0;
               end else begin
                  exp_view[c] = steps[s].exp[c];
               end
            end
            starts   = 0;
            check_en = 1'b1;
            while (starts < check_starts) @(posedge clk_33);
            check_en = 1'b0;
         end
      end
      host_valid <= 1'b0;
      @(posedge clk_33);
      $display("checks: %0d, errors: %0d, cycles: %0d", check_count, error_count, cycle_count);
      if (error_count == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule
